/* ctrl_vectors.txt */
# Controller path vectors, one test per line, fields in hex
# op  a         b         swap ksel_n jsel_n
# I idle check over all strobe states, J joystick set with a = joy0 and b = joy1
# P PS/2 event with a = scan code and b = pressed, S the same with bit 10 held
# R random burst with a = cycle count
I 0        0        0 3 3
# Keypad priority, keypad strobes low
J 00000100 00000200 0 0 3
J 00000400 00000800 0 0 3
J 00001000 00002000 0 0 3
J 00004000 00008000 0 0 3
J 00010000 00020000 0 0 3
J 00000040 00000080 0 0 3
J 00040000 00080000 0 0 3
J 000A0C00 000C0040 0 0 3
J 00000020 00000000 0 0 3
J 00000020 00000020 0 2 3
# Joystick segment, direction strobes low
J 00000008 00000004 0 3 0
J 00000002 00000001 0 3 0
J 00000009 00000016 0 3 0
J 00000010 0000000F 0 3 0
# Both strobes low
J 00000409 00020836 0 0 0
J 000FFFFF 00000000 0 0 0
# Swap toggles
J 00000208 00001004 0 0 0
J 00000208 00001004 1 0 0
J 00000208 00001004 0 0 0
J 00000208 00001034 1 1 2
# PS/2 emulation with joysticks idle
J 00000000 00000000 0 0 3
P 016 1 0 0 3
P 016 0 0 0 3
P 070 1 0 0 3
P 070 0 0 0 3
P 012 1 0 0 3
P 03E 1 0 0 3
P 03E 0 0 0 3
P 026 1 0 0 3
P 026 0 0 0 3
P 012 0 0 0 3
P 07B 1 0 0 3
P 07B 0 0 0 3
P 07C 1 0 0 3
S 07C 0 0 0 3
P 07C 0 0 0 3
P 170 1 0 0 3
P 170 0 0 0 3
P 059 1 0 0 3
P 075 1 0 0 3
P 075 0 0 0 3
P 059 0 0 0 3
# Random burst of 200 cycles, then idle again
R C8       0        0 0 0
I 0        0        0 3 3

/* src.f */
ctrl_pkg.sv
ps2_keypad_decoder.sv
keypad_merge.sv
controller_port.sv
ctrl_top.sv
tb_clk_gen.sv
tb_ctrl_top.sv

/* Makefile */
TOP := tb_ctrl_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module ctrl_top \
		ctrl_pkg.sv ps2_keypad_decoder.sv keypad_merge.sv \
		controller_port.sv ctrl_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_ctrl_top.sv */
`timescale 1ns/1ps

module tb_ctrl_top;
        import ctrl_pkg::*;

        logic                  clk_sys;
        logic                  rst_i;
        logic [JOY_W-1:0]      joy0_i;
        logic [JOY_W-1:0]      joy1_i;
        logic                  swap_i;
        logic [PS2_W-1:0]      ps2_key_i;
        logic [1:0]            keypad_sel_n_i;
        logic [1:0]            joy_sel_n_i;
        logic [LINE_W-1:0]     port0_lines_o;
        logic [LINE_W-1:0]     port1_lines_o;
        logic [1:0]            fire_n_o;

        // Model of the held keyboard buttons
        logic [NUM_DIGITS-1:0] m_digit;
        logic                  m_star;
        logic                  m_minus;
        logic                  m_shift;

        integer                seed;
        int                    test_count;
        int                    fail_count;
        int                    error_count;
        int                    test_errors;

        tb_clk_gen clk_gen_i (
                .clk_o (clk_sys)
        );

        ctrl_top ctrl_top_i (
                .clk_sys        (clk_sys),
                .rst_i          (rst_i),
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .swap_i         (swap_i),
                .ps2_key_i      (ps2_key_i),
                .keypad_sel_n_i (keypad_sel_n_i),
                .joy_sel_n_i    (joy_sel_n_i),
                .port0_lines_o  (port0_lines_o),
                .port1_lines_o  (port1_lines_o),
                .fire_n_o       (fire_n_o)
        );

        // ====================
        // Reference model
        // ====================

        // Host word bits: 0-3 right/left/down/up, 4-5 fires, 6-7 star/number,
        // 8-17 digits, 18-19 purple/blue
        function automatic logic [KEYPAD_W-1:0] map_joy(input logic [JOY_W-1:0] joy);
                logic [KEYPAD_W-1:0] kp;
                kp = '0;
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        kp[KP_DIGIT0 + i] = joy[8 + i];
                end
                kp[KP_STAR]   = joy[6];
                kp[KP_NUMBER] = joy[7];
                kp[KP_PURPLE] = joy[18];
                kp[KP_BLUE]   = joy[19];
                kp[KP_UP]     = joy[3];
                kp[KP_DOWN]   = joy[2];
                kp[KP_LEFT]   = joy[1];
                kp[KP_RIGHT]  = joy[0];
                kp[KP_FIRE1]  = joy[4];
                kp[KP_FIRE2]  = joy[5];
                return kp;
        endfunction

        function automatic logic [KEYPAD_W-1:0] model_emu();
                logic [KEYPAD_W-1:0] e;
                e = '0;
                e[KP_DIGIT0 +: NUM_DIGITS] = m_digit;
                e[KP_STAR]   = m_star | (m_digit[8] & m_shift);
                e[KP_NUMBER] = m_minus | (m_digit[3] & m_shift);
                return e;
        endfunction

        function automatic logic [LINE_W-1:0] cv_code(input int idx);
                case (idx)
                        0:       return CV_KEY_0;
                        1:       return CV_KEY_1;
                        2:       return CV_KEY_2;
                        3:       return CV_KEY_3;
                        4:       return CV_KEY_4;
                        5:       return CV_KEY_5;
                        6:       return CV_KEY_6;
                        7:       return CV_KEY_7;
                        8:       return CV_KEY_8;
                        9:       return CV_KEY_9;
                        10:      return CV_KEY_STAR;
                        11:      return CV_KEY_NUMBER;
                        12:      return CV_KEY_PT;
                        13:      return CV_KEY_BT;
                        default: return CV_KEY_NONE;
                endcase
        endfunction

        // Fire in bit 4, lines in bits 3:0
        function automatic logic [LINE_W:0] encode(
                input logic [KEYPAD_W-1:0] kp,
                input logic                ksel_n,
                input logic                jsel_n
        );
                logic [LINE_W-1:0] code;
                logic [LINE_W-1:0] dir;
                logic              fire_a;
                logic              fire_b;
                code   = CV_KEY_NONE;
                dir    = 4'hf;
                fire_a = 1'b1;
                fire_b = 1'b1;
                if (!ksel_n) begin
                        // No key code equals the none code, so the first hit sticks
                        for (int i = 0; i < KP_KEYS; i++) begin
                                if (kp[i] && code == CV_KEY_NONE) begin
                                        code = cv_code(i);
                                end
                        end
                        fire_a = ~kp[KP_FIRE2];
                end
                if (!jsel_n) begin
                        dir    = ~{kp[KP_UP], kp[KP_DOWN], kp[KP_LEFT], kp[KP_RIGHT]};
                        fire_b = ~kp[KP_FIRE1];
                end
                return {fire_a & fire_b, code & dir};
        endfunction

        // Top-row and keypad digits hit the same button
        task automatic apply_event(input logic [8:0] code, input logic pressed);
                case (code[7:0])
                        8'h45, 8'h70: m_digit[0] = pressed;
                        8'h16, 8'h69: m_digit[1] = pressed;
                        8'h1E, 8'h72: m_digit[2] = pressed;
                        8'h26, 8'h7A: m_digit[3] = pressed;
                        8'h25, 8'h6B: m_digit[4] = pressed;
                        8'h2E, 8'h73: m_digit[5] = pressed;
                        8'h36, 8'h74: m_digit[6] = pressed;
                        8'h3D, 8'h6C: m_digit[7] = pressed;
                        8'h3E, 8'h75: m_digit[8] = pressed;
                        8'h46, 8'h7D: m_digit[9] = pressed;
                        8'h7C:        m_star     = pressed;
                        8'h7B:        m_minus    = pressed;
                        8'h12, 8'h59: m_shift    = pressed;
                        default:      ;
                endcase
        endtask

        // ====================
        // Checks and stimulus
        // ====================

        task automatic check_outputs();
                logic [KEYPAD_W-1:0] kp0;
                logic [KEYPAD_W-1:0] kp1;
                logic [LINE_W:0]     exp0;
                logic [LINE_W:0]     exp1;
                kp0  = map_joy(swap_i ? joy1_i : joy0_i) | model_emu();
                kp1  = map_joy(swap_i ? joy0_i : joy1_i) | model_emu();
                exp0 = encode(kp0, keypad_sel_n_i[0], joy_sel_n_i[0]);
                exp1 = encode(kp1, keypad_sel_n_i[1], joy_sel_n_i[1]);
                if (port0_lines_o !== exp0[LINE_W-1:0]) begin
                        $display("[FAIL] port0_lines_o expected %h got %h",
                                 exp0[LINE_W-1:0], port0_lines_o);
                        test_errors++;
                end
                if (port1_lines_o !== exp1[LINE_W-1:0]) begin
                        $display("[FAIL] port1_lines_o expected %h got %h",
                                 exp1[LINE_W-1:0], port1_lines_o);
                        test_errors++;
                end
                if (fire_n_o !== {exp1[LINE_W], exp0[LINE_W]}) begin
                        $display("[FAIL] fire_n_o expected %h got %h",
                                 {exp1[LINE_W], exp0[LINE_W]}, fire_n_o);
                        test_errors++;
                end
        endtask

        task automatic next_cycles(input int n);
                for (int i = 0; i < n; i++) begin
                        @(negedge clk_sys);
                end
        endtask

        task automatic random_burst(input int n);
                logic [31:0] r;
                for (int i = 0; i < n; i++) begin
                        joy0_i         = $random(seed);
                        joy1_i         = $random(seed);
                        r              = $random(seed);
                        swap_i         = r[0];
                        keypad_sel_n_i = r[2:1];
                        joy_sel_n_i    = r[4:3];
                        next_cycles(1);
                        check_outputs();
                end
        endtask

        // Called on a falling edge, so every drive below lands there
        task automatic run_line(
                input logic [7:0]  op,
                input logic [31:0] a,
                input logic [31:0] b,
                input logic [31:0] sw,
                input logic [31:0] ks,
                input logic [31:0] js
        );
                logic [KEYPAD_W-1:0] exp_emu;
                test_errors    = 0;
                keypad_sel_n_i = ks[1:0];
                joy_sel_n_i    = js[1:0];
                case (op)
                        "I": begin
                                for (int c = 0; c < 16; c++) begin
                                        keypad_sel_n_i = c[1:0];
                                        joy_sel_n_i    = c[3:2];
                                        next_cycles(1);
                                        check_outputs();
                                end
                        end
                        "J": begin
                                joy0_i = a;
                                joy1_i = b;
                                swap_i = sw[0];
                                next_cycles(1);
                                check_outputs();
                        end
                        "P", "S": begin
                                swap_i    = sw[0];
                                ps2_key_i = {(op == "P") ? ~ps2_key_i[10] : ps2_key_i[10],
                                             b[0], a[8:0]};
                                if (op == "P") begin
                                        apply_event(a[8:0], b[0]);
                                end
                                next_cycles(2);
                                check_outputs();
                                // Shift combinations hide behind their digit on the lines
                                exp_emu = model_emu();
                                if (ctrl_top_i.emu_keys !== exp_emu[EMU_W-1:0]) begin
                                        $display("[FAIL] emu_keys expected %h got %h",
                                                 exp_emu[EMU_W-1:0], ctrl_top_i.emu_keys);
                                        test_errors++;
                                end
                        end
                        "R": begin
                                random_burst(int'(a));
                        end
                        default: begin
                                $display("Unknown operation %c in the vector file", op);
                                test_errors++;
                        end
                endcase
                test_count++;
                error_count += test_errors;
                if (test_errors != 0) begin
                        fail_count++;
                end
                $display("test %0d op %c: %0d errors", test_count, op, test_errors);
        endtask

        // ====================
        // Main sequence
        // ====================

        initial begin
                int          fd;
                int          status;
                int          lines_read;
                string       line;
                logic [7:0]  op;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] sw;
                logic [31:0] ks;
                logic [31:0] js;
                seed           = 32'h7b12d3ba;
                test_count     = 0;
                fail_count     = 0;
                error_count    = 0;
                test_errors    = 0;
                m_digit        = '0;
                m_star         = 1'b0;
                m_minus        = 1'b0;
                m_shift        = 1'b0;
                rst_i          = 1'b1;
                joy0_i         = '0;
                joy1_i         = '0;
                swap_i         = 1'b0;
                ps2_key_i      = '0;
                keypad_sel_n_i = 2'b11;
                joy_sel_n_i    = 2'b11;

                // Reset spans eight rising edges from the first one
                @(posedge clk_sys);
                next_cycles(8);
                rst_i = 1'b0;

                fd = $fopen("ctrl_vectors.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the vector file ctrl_vectors.txt");
                        error_count++;
                end else begin
                        lines_read = 0;
                        while (!$feof(fd) && lines_read < 200) begin
                                status = $fgets(line, fd);
                                lines_read++;
                                if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
                                        status = $sscanf(line, "%c %h %h %h %h %h",
                                                         op, a, b, sw, ks, js);
                                        if (status == 6) begin
                                                run_line(op, a, b, sw, ks, js);
                                        end else begin
                                                $display("Vector line %0d is malformed", lines_read);
                                                error_count++;
                                        end
                                end
                        end
                        if (lines_read == 200) begin
                                $display("Vector file did not end within 200 lines");
                                error_count++;
                        end
                        $fclose(fd);
                end

                $display("%0d tests run, %0d failed, %0d errors",
                         test_count, fail_count, error_count);
                if (error_count == 0 && test_count > 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

        // Watchdog for a run that never reaches the end
        initial begin
                #20000;
                $display("Simulation did not finish within 20000 ns");
                $display("Test failed");
                $finish;
        end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
        output logic clk_o
);

        // Free running clock, 4 ns period
        initial begin
                clk_o = 1'b0;
                forever begin
                        // Half period
                        #2 clk_o = ~clk_o;
                end
        end

endmodule

/* ctrl_top.sv */
`timescale 1ns/1ps

module ctrl_top (
        input  logic                        clk_sys,
        input  logic                        rst_i,
        input  logic [ctrl_pkg::JOY_W-1:0]  joy0_i,
        input  logic [ctrl_pkg::JOY_W-1:0]  joy1_i,
        input  logic                        swap_i,
        input  logic [ctrl_pkg::PS2_W-1:0]  ps2_key_i,
        input  logic [1:0]                  keypad_sel_n_i,
        input  logic [1:0]                  joy_sel_n_i,
        output logic [ctrl_pkg::LINE_W-1:0] port0_lines_o,
        output logic [ctrl_pkg::LINE_W-1:0] port1_lines_o,
        output logic [1:0]                  fire_n_o
);
        import ctrl_pkg::*;

        logic [EMU_W-1:0]    emu_keys;
        logic [KEYPAD_W-1:0] kp0;
        logic [KEYPAD_W-1:0] kp1;

        // ====================
        // Input side
        // ====================

        ps2_keypad_decoder ps2_keypad_decoder_i (
                .clk_sys    (clk_sys),
                .rst_i      (rst_i),
                .ps2_key_i  (ps2_key_i),
                .emu_keys_o (emu_keys)
        );

        keypad_merge keypad_merge_i (
                .clk_sys    (clk_sys),
                .rst_i      (rst_i),
                .joy0_i     (joy0_i),
                .joy1_i     (joy1_i),
                .swap_i     (swap_i),
                .emu_keys_i (emu_keys),
                .kp0_o      (kp0),
                .kp1_o      (kp1)
        );

        // ====================
        // Controller ports
        // ====================

        // Player A
        controller_port port0_i (
                .keypad_sel_n_i (keypad_sel_n_i[0]),
                .joy_sel_n_i    (joy_sel_n_i[0]),
                .kp_i           (kp0),
                .lines_o        (port0_lines_o),
                .fire_n_o       (fire_n_o[0])
        );

        // Player B
        controller_port port1_i (
                .keypad_sel_n_i (keypad_sel_n_i[1]),
                .joy_sel_n_i    (joy_sel_n_i[1]),
                .kp_i           (kp1),
                .lines_o        (port1_lines_o),
                .fire_n_o       (fire_n_o[1])
        );

endmodule

/* controller_port.sv */
`timescale 1ns/1ps

module controller_port (
        input  logic                          keypad_sel_n_i,
        input  logic                          joy_sel_n_i,
        input  logic [ctrl_pkg::KEYPAD_W-1:0] kp_i,
        output logic [ctrl_pkg::LINE_W-1:0]   lines_o,
        output logic                          fire_n_o
);
        import ctrl_pkg::*;

        logic [LINE_W-1:0] key_code_w;
        logic [LINE_W-1:0] pad_code_w;
        logic [LINE_W-1:0] dir_w;
        logic              fire_a_w;
        logic              fire_b_w;

        // ====================
        // Keypad segment
        // ====================

        // Priority encoder, lowest index wins
        always_comb begin
                key_code_w = CV_KEY_NONE;
                for (int i = KP_KEYS - 1; i >= 0; i--) begin
                        if (kp_i[i]) begin
                                key_code_w = CV_KEY_TABLE[i];
                        end
                end
        end

        // Keypad strobe gates code and fire 2
        assign pad_code_w = keypad_sel_n_i ? CV_KEY_NONE : key_code_w;
        assign fire_a_w   = keypad_sel_n_i | ~kp_i[KP_FIRE2];

        // ====================
        // Joystick segment
        // ====================

        // Up on line bit 3 down to right on bit 0
        assign dir_w = joy_sel_n_i ? {LINE_W{1'b1}} :
                       ~{kp_i[KP_UP], kp_i[KP_DOWN], kp_i[KP_LEFT], kp_i[KP_RIGHT]};

        assign fire_b_w = joy_sel_n_i | ~kp_i[KP_FIRE1];

        // ====================
        // Line merge
        // ====================

        // Active low lines, so either segment can pull a bit down
        assign lines_o  = pad_code_w & dir_w;
        assign fire_n_o = fire_a_w & fire_b_w;

        // Port idles high while the console selects neither segment
        always_comb begin
                if (keypad_sel_n_i && joy_sel_n_i) begin
                        a_idle_high: assert final (lines_o == {LINE_W{1'b1}} && fire_n_o)
                                else $error("port not idle with both selects high");
                end
        end

endmodule

/* keypad_merge.sv */
`timescale 1ns/1ps

module keypad_merge (
        input  logic                          clk_sys,
        input  logic                          rst_i,
        input  logic [ctrl_pkg::JOY_W-1:0]    joy0_i,
        input  logic [ctrl_pkg::JOY_W-1:0]    joy1_i,
        input  logic                          swap_i,
        input  logic [ctrl_pkg::EMU_W-1:0]    emu_keys_i,
        output logic [ctrl_pkg::KEYPAD_W-1:0] kp0_o,
        output logic [ctrl_pkg::KEYPAD_W-1:0] kp1_o
);
        import ctrl_pkg::*;

        logic [JOY_W-1:0]    joy_a_w;
        logic [JOY_W-1:0]    joy_b_w;
        logic [KEYPAD_W-1:0] emu_w;

        // Host word order into keypad order
        function automatic logic [KEYPAD_W-1:0] joy_to_keypad(input logic [JOY_W-1:0] joy);
                logic [KEYPAD_W-1:0] kp;
                kp = '0;
                kp[KP_DIGIT0 +: NUM_DIGITS] = joy[JOY_DIGIT0 +: NUM_DIGITS];
                kp[KP_STAR]   = joy[JOY_STAR];
                kp[KP_NUMBER] = joy[JOY_NUMBER];
                kp[KP_PURPLE] = joy[JOY_PURPLE];
                kp[KP_BLUE]   = joy[JOY_BLUE];
                kp[KP_UP]     = joy[JOY_UP];
                kp[KP_DOWN]   = joy[JOY_DOWN];
                kp[KP_LEFT]   = joy[JOY_LEFT];
                kp[KP_RIGHT]  = joy[JOY_RIGHT];
                kp[KP_FIRE1]  = joy[JOY_FIRE1];
                kp[KP_FIRE2]  = joy[JOY_FIRE2];
                return kp;
        endfunction

        // Player swap
        assign joy_a_w = swap_i ? joy1_i : joy0_i;
        assign joy_b_w = swap_i ? joy0_i : joy1_i;

        // Keyboard keys land on the low keypad entries of both players
        assign emu_w = {{(KEYPAD_W-EMU_W){1'b0}}, emu_keys_i};

        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        kp0_o <= '0;
                        kp1_o <= '0;
                end else begin
                        kp0_o <= joy_to_keypad(joy_a_w) | emu_w;
                        kp1_o <= joy_to_keypad(joy_b_w) | emu_w;
                end
        end

        // Swap with everything else held just exchanges the players
        a_swap_exchanges: assert property (
                @(posedge clk_sys) disable iff (rst_i)
                ($changed(swap_i) && !$past(rst_i) && $stable(joy0_i) &&
                 $stable(joy1_i) && $stable(emu_keys_i))
                |=> (kp0_o == $past(kp1_o) && kp1_o == $past(kp0_o))
        ) else $error("player vectors not exchanged after swap");

endmodule

/* ps2_keypad_decoder.sv */
`timescale 1ns/1ps

module ps2_keypad_decoder (
        input  logic                       clk_sys,
        input  logic                       rst_i,
        input  logic [ctrl_pkg::PS2_W-1:0] ps2_key_i,
        output logic [ctrl_pkg::EMU_W-1:0] emu_keys_o
);
        import ctrl_pkg::*;

        // ====================
        // Event detection
        // ====================

        logic                  toggle_q;
        logic                  event_w;
        logic                  pressed_w;
        logic [SC_W-1:0]       code_w;

        // Held buttons
        logic [NUM_DIGITS-1:0] digit_q;
        logic                  star_q;
        logic                  shift_q;
        logic                  minus_q;

        // A new event flips the toggle bit
        assign event_w   = ps2_key_i[PS2_TOGGLE] != toggle_q;
        assign pressed_w = ps2_key_i[PS2_PRESSED];

        // Extended flag in bit 8 plays no part in the match
        assign code_w    = ps2_key_i[SC_W-1:0];

        // Toggle tracks the input in and out of reset
        always_ff @(posedge clk_sys) begin
                toggle_q <= ps2_key_i[PS2_TOGGLE];
        end

        // ====================
        // Button registers
        // ====================

        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        digit_q <= '0;
                        star_q  <= 1'b0;
                        shift_q <= 1'b0;
                        minus_q <= 1'b0;
                end else if (event_w) begin
                        // Top row and keypad digits share one button
                        for (int i = 0; i < NUM_DIGITS; i++) begin
                                if (code_w == SC_TOP_DIGIT[i] ||
                                    code_w == SC_PAD_DIGIT[i]) begin
                                        digit_q[i] <= pressed_w;
                                end
                        end

                        if (code_w == SC_PAD_STAR) begin
                                star_q <= pressed_w;
                        end

                        if (code_w == SC_PAD_MINUS) begin
                                minus_q <= pressed_w;
                        end

                        // Either shift key
                        if (code_w == SC_LSHIFT || code_w == SC_RSHIFT) begin
                                shift_q <= pressed_w;
                        end
                end
        end

        // ====================
        // Emulated keypad
        // ====================

        assign emu_keys_o[KP_DIGIT0 +: NUM_DIGITS] = digit_q;

        // Shift+8 doubles as star, shift+3 as number
        assign emu_keys_o[KP_STAR]   = star_q | (digit_q[8] & shift_q);
        assign emu_keys_o[KP_NUMBER] = minus_q | (digit_q[3] & shift_q);

        // No button may survive a reset
        a_clear_after_reset: assert property (
                @(posedge clk_sys) rst_i |=> (emu_keys_o == '0)
        ) else $error("emulated keys not clear after reset");

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

        // ====================
        // Widths
        // ====================
        localparam int JOY_W      = 32;
        localparam int PS2_W      = 11;
        localparam int KEYPAD_W   = 20;
        localparam int EMU_W      = 12;
        localparam int LINE_W     = 4;
        localparam int NUM_DIGITS = 10;
        localparam int SC_W       = 8;

        // PS/2 event word fields
        localparam int PS2_TOGGLE  = 10;
        localparam int PS2_PRESSED = 9;

        // Host joystick word bit positions
        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_NUMBER = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PURPLE = 18;
        localparam int JOY_BLUE   = 19;

        // ====================
        // Keypad vector layout
        // ====================
        localparam int KP_DIGIT0 = 0;
        localparam int KP_STAR   = 10;
        localparam int KP_NUMBER = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        localparam int KP_UP     = 14;
        localparam int KP_DOWN   = 15;
        localparam int KP_LEFT   = 16;
        localparam int KP_RIGHT  = 17;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;
        localparam int KP_KEYS   = 14;

        // ====================
        // Controller key codes
        // ====================
        localparam logic [LINE_W-1:0] CV_KEY_0      = 4'b0011;
        localparam logic [LINE_W-1:0] CV_KEY_1      = 4'b1110;
        localparam logic [LINE_W-1:0] CV_KEY_2      = 4'b1101;
        localparam logic [LINE_W-1:0] CV_KEY_3      = 4'b0110;
        localparam logic [LINE_W-1:0] CV_KEY_4      = 4'b0001;
        localparam logic [LINE_W-1:0] CV_KEY_5      = 4'b1001;
        localparam logic [LINE_W-1:0] CV_KEY_6      = 4'b0111;
        localparam logic [LINE_W-1:0] CV_KEY_7      = 4'b1100;
        localparam logic [LINE_W-1:0] CV_KEY_8      = 4'b1000;
        localparam logic [LINE_W-1:0] CV_KEY_9      = 4'b1011;
        localparam logic [LINE_W-1:0] CV_KEY_STAR   = 4'b1010;
        localparam logic [LINE_W-1:0] CV_KEY_NUMBER = 4'b0101;
        localparam logic [LINE_W-1:0] CV_KEY_PT     = 4'b0100;
        localparam logic [LINE_W-1:0] CV_KEY_BT     = 4'b0010;
        localparam logic [LINE_W-1:0] CV_KEY_NONE   = 4'b1111;

        // Code per keypad index, 0 to KP_KEYS-1
        localparam logic [LINE_W-1:0] CV_KEY_TABLE [KP_KEYS] = '{
                CV_KEY_0, CV_KEY_1, CV_KEY_2, CV_KEY_3, CV_KEY_4,
                CV_KEY_5, CV_KEY_6, CV_KEY_7, CV_KEY_8, CV_KEY_9,
                CV_KEY_STAR, CV_KEY_NUMBER, CV_KEY_PT, CV_KEY_BT
        };

        // ====================
        // PS/2 scan codes
        // ====================
        localparam logic [SC_W-1:0] SC_TOP_DIGIT [NUM_DIGITS] = '{
                8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
        };
        localparam logic [SC_W-1:0] SC_PAD_DIGIT [NUM_DIGITS] = '{
                8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
        };
        localparam logic [SC_W-1:0] SC_PAD_STAR  = 8'h7C;
        localparam logic [SC_W-1:0] SC_PAD_MINUS = 8'h7B;
        localparam logic [SC_W-1:0] SC_LSHIFT    = 8'h12;
        localparam logic [SC_W-1:0] SC_RSHIFT    = 8'h59;

endpackage
